/* design/dcache_defs.svh */
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// data and address word
`define DC_WORD_W 32

// geometry, 8 sets of two ways
`define DC_SETS   8
`define DC_IDX_W  3

// address split: tag | idx | blkoff | bytoff
`define DC_TAG_W  26
`define DC_BLK_W  1
`define DC_BYT_W  2

// frames visited by the halt flush (sets x ways)
`define DC_FRAMES 16

`endif

/* design/dcache_addr_pkg.sv */
`include "dcache_defs.svh"

package dcache_addr_pkg;

    typedef logic [`DC_WORD_W-1:0] word_t;

    // field view of an address word
    typedef struct packed {
        logic [`DC_TAG_W-1:0] tag;
        logic [`DC_IDX_W-1:0] idx;
        logic [`DC_BLK_W-1:0] blkoff;
        logic [`DC_BYT_W-1:0] bytoff;
    } addr_fields_t;

    // flat word on the buses, fields for lookup
    typedef union packed {
        word_t        word;
        addr_fields_t f;
    } dcache_addr_u;

    // one cache frame, 92 bits
    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [`DC_TAG_W-1:0] tag;
        word_t [1:0]          data;   // indexed by blkoff
    } frame_t;

    typedef logic way_t;
    typedef logic [`DC_IDX_W-1:0] idx_t;

endpackage

/* design/dcache_bus_pkg.sv */
`include "dcache_defs.svh"

package dcache_bus_pkg;

    typedef struct packed {
        logic                         ren;
        logic                         wen;
        dcache_addr_pkg::dcache_addr_u addr;
        dcache_addr_pkg::word_t        store;
    } dp_req_t;

    typedef struct packed {
        logic                   hit;      // one-cycle pulse
        dcache_addr_pkg::word_t load;
        logic                   flushed;  // level, held until reset
    } dp_rsp_t;

    typedef struct packed {
        logic                   ren;
        logic                   wen;
        dcache_addr_pkg::word_t addr;
        dcache_addr_pkg::word_t store;
    } mem_req_t;

    typedef struct packed {
        logic                   dwait;
        dcache_addr_pkg::word_t load;
    } mem_rsp_t;

    typedef struct packed {
        logic                    hit;
        dcache_addr_pkg::way_t   hit_way;
        dcache_addr_pkg::word_t  rdata;
        dcache_addr_pkg::way_t   victim_way;
        dcache_addr_pkg::frame_t victim;
    } lookup_t;

    typedef enum logic [2:0] {
        op_none, op_store_word, op_fill_word, op_clean, op_touch
    } frame_op_e;

    typedef struct packed {
        frame_op_e              op;
        dcache_addr_pkg::way_t  way;
        dcache_addr_pkg::idx_t  idx;
        logic [`DC_BLK_W-1:0]   word;
        logic [`DC_TAG_W-1:0]   tag;
        dcache_addr_pkg::word_t data;
    } frame_cmd_t;

endpackage

/* design/dcache_lookup.sv */
`timescale 1ns/1ps

module dcache_lookup (
    input  dcache_bus_pkg::dp_req_t          req,
    input  dcache_addr_pkg::frame_t [1:0]    set_frames,
    input  dcache_addr_pkg::way_t            last_used,
    output dcache_bus_pkg::lookup_t          result
);

    logic [1:0]                    match;
    dcache_addr_pkg::way_t         hit_way;
    dcache_addr_pkg::way_t         victim_way;
    dcache_addr_pkg::frame_t       hit_frame;

    // tag compare against both ways of the set
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            match[w] = set_frames[w].valid &&
                       (set_frames[w].tag == req.addr.f.tag);
        end
    end

    // at most one way can match, so way 1 alone decides
    assign hit_way    = match[1];
    assign hit_frame  = set_frames[hit_way];

    // replace the way that was not touched last
    assign victim_way = ~last_used;

    always_comb begin
        result            = '0;
        result.hit        = |match;
        result.hit_way    = hit_way;
        result.rdata      = hit_frame.data[req.addr.f.blkoff];  // addressed word
        result.victim_way = victim_way;
        result.victim     = set_frames[victim_way];
    end

endmodule

/* design/dcache_frames.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_frames (
    input  logic                           CLK,
    input  logic                           nRST,
    input  dcache_addr_pkg::idx_t          rd_idx,
    input  dcache_bus_pkg::frame_cmd_t     cmd,
    output dcache_addr_pkg::frame_t [1:0]  set_frames,
    output dcache_addr_pkg::way_t          last_used
);

    // frame store indexed by set and way
    dcache_addr_pkg::frame_t [`DC_SETS-1:0][1:0] sets;
    logic [`DC_SETS-1:0]                         lru_bits;  // way last used per set

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            sets     <= '0;   // all invalid and clean
            lru_bits <= '0;
        end else begin
            case (cmd.op)
                dcache_bus_pkg::op_store_word: begin
                    sets[cmd.idx][cmd.way].data[cmd.word] <= cmd.data;
                    sets[cmd.idx][cmd.way].dirty          <= 1'b1;
                    lru_bits[cmd.idx]                     <= cmd.way;
                end
                dcache_bus_pkg::op_fill_word: begin
                    // valid after the first word while the controller fetches the second
                    sets[cmd.idx][cmd.way].data[cmd.word] <= cmd.data;
                    sets[cmd.idx][cmd.way].tag            <= cmd.tag;
                    sets[cmd.idx][cmd.way].valid          <= 1'b1;
                    sets[cmd.idx][cmd.way].dirty          <= 1'b0;
                end
                dcache_bus_pkg::op_clean: begin
                    sets[cmd.idx][cmd.way].dirty <= 1'b0;  // after write-back
                end
                dcache_bus_pkg::op_touch: begin
                    lru_bits[cmd.idx] <= cmd.way;
                end
                default: begin
                end
            endcase
        end
    end

    // read-out of the selected set
    assign set_frames = sets[rd_idx];
    assign last_used  = lru_bits[rd_idx];

endmodule

/* design/dcache_mem_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module dcache_mem_ctrl (
    input  logic                        CLK,
    input  logic                        nRST,
    input  dcache_bus_pkg::dp_req_t     req,
    input  logic                        halt,
    input  dcache_bus_pkg::lookup_t     result,
    input  dcache_bus_pkg::mem_rsp_t    mem_rsp,
    output dcache_addr_pkg::idx_t       rd_idx,
    output dcache_bus_pkg::frame_cmd_t  cmd,
    output dcache_bus_pkg::dp_rsp_t     rsp,
    output dcache_bus_pkg::mem_req_t    mem_req
);

    typedef enum logic [3:0] {
        st_idle, st_wb0, st_wb1, st_fill0, st_fill1,
        st_flush_scan, st_flush0, st_flush1, st_halted
    } state_e;

    state_e                        state, next_state;
    logic [4:0]                    frame_cnt, next_cnt;  // way in bit 3, set in 2:0
    logic                          flushing;
    dcache_addr_pkg::way_t         scan_way;
    dcache_addr_pkg::dcache_addr_u blk_addr;

    assign flushing = (state == st_flush_scan) || (state == st_flush0) ||
                      (state == st_flush1);
    assign scan_way = frame_cnt[3];   // way 0 first and then way 1

    // set to read comes from the request or the flush walk
    assign rd_idx = flushing ? frame_cnt[2:0] : req.addr.f.idx;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= st_idle;
            frame_cnt <= '0;
        end else begin
            state     <= next_state;
            frame_cnt <= next_cnt;
        end
    end

    // memory block address
    always_comb begin
        blk_addr.word     = req.addr.word;
        blk_addr.f.idx    = rd_idx;
        blk_addr.f.blkoff = '0;
        blk_addr.f.bytoff = '0;
        if (state inside {st_wb0, st_wb1, st_flush0, st_flush1})
            blk_addr.f.tag = result.victim.tag;   // write-back uses the victim's own tag
        if (state inside {st_wb1, st_fill1, st_flush1})
            blk_addr.f.blkoff = 1'b1;             // second word
    end

    always_comb begin
        next_state   = state;
        next_cnt     = frame_cnt;
        cmd          = '0;
        cmd.idx      = rd_idx;
        rsp          = '0;
        rsp.load     = result.rdata;
        rsp.flushed  = (state == st_halted);
        mem_req      = '0;
        mem_req.addr = blk_addr.word;

        case (state)
            st_idle: begin
                if (halt) begin
                    next_state = st_flush_scan;
                    next_cnt   = '0;
                end else if (req.ren || req.wen) begin
                    if (result.hit) begin
                        rsp.hit  = 1'b1;
                        cmd.op   = req.wen ? dcache_bus_pkg::op_store_word
                                           : dcache_bus_pkg::op_touch;
                        cmd.way  = result.hit_way;
                        cmd.word = req.addr.f.blkoff;
                        cmd.data = req.store;
                    end else begin
                        // on a miss the dirty victim goes out first
                        next_state = result.victim.dirty ? st_wb0 : st_fill0;
                    end
                end
            end

            st_wb0, st_wb1, st_flush0, st_flush1: begin
                mem_req.wen   = 1'b1;
                mem_req.store = result.victim.data[blk_addr.f.blkoff];
                if (!mem_rsp.dwait) begin
                    case (state)
                        st_wb0:    next_state = st_wb1;
                        st_wb1:    next_state = st_fill0;
                        st_flush0: next_state = st_flush1;
                        default: begin
                            // frame is clean again once flush1 completes
                            next_state = st_flush_scan;
                            next_cnt   = frame_cnt + 5'd1;
                            cmd.op     = dcache_bus_pkg::op_clean;
                            cmd.way    = scan_way;
                        end
                    endcase
                end
            end

            st_fill0, st_fill1: begin
                mem_req.ren = 1'b1;
                if (!mem_rsp.dwait) begin
                    next_state = (state == st_fill0) ? st_fill1 : st_idle;
                    cmd.op     = dcache_bus_pkg::op_fill_word;
                    cmd.way    = result.victim_way;
                    cmd.word   = blk_addr.f.blkoff;
                    cmd.tag    = req.addr.f.tag;
                    cmd.data   = mem_rsp.load;
                end
            end

            st_flush_scan: begin
                if (frame_cnt == 5'(`DC_FRAMES)) begin
                    next_state = st_halted;
                end else if (result.victim_way != scan_way) begin
                    // lookup only shows the victim frame, so steer it onto the scanned way
                    cmd.op  = dcache_bus_pkg::op_touch;
                    cmd.way = ~scan_way;
                end else if (result.victim.dirty) begin
                    next_state = st_flush0;
                end else begin
                    next_cnt = frame_cnt + 5'd1;   // clean frame is skipped
                end
            end

            default: begin
                // flushed stays up until reset
            end
        endcase
    end

endmodule

/* design/dcache.sv */
`timescale 1ns/1ps

module dcache (
    input  logic                      CLK,
    input  logic                      nRST,
    input  dcache_bus_pkg::dp_req_t   dp_req,
    input  logic                      halt,
    output dcache_bus_pkg::dp_rsp_t   dp_rsp,
    output dcache_bus_pkg::mem_req_t  mem_req,
    input  dcache_bus_pkg::mem_rsp_t  mem_rsp
);

    dcache_addr_pkg::idx_t          rd_idx;
    dcache_addr_pkg::frame_t [1:0]  set_frames;
    dcache_addr_pkg::way_t          last_used;
    dcache_bus_pkg::lookup_t        result;
    dcache_bus_pkg::frame_cmd_t     cmd;

    // hit check and victim choice on the current set
    dcache_lookup i_lookup (
        .req        (dp_req),
        .set_frames (set_frames),
        .last_used  (last_used),
        .result     (result)
    );

    dcache_frames i_frames (
        .CLK        (CLK),
        .nRST       (nRST),
        .rd_idx     (rd_idx),
        .cmd        (cmd),
        .set_frames (set_frames),
        .last_used  (last_used)
    );

    // hits, miss handling and flush
    dcache_mem_ctrl i_mem_ctrl (
        .CLK     (CLK),
        .nRST    (nRST),
        .req     (dp_req),
        .halt    (halt),
        .result  (result),
        .mem_rsp (mem_rsp),
        .rd_idx  (rd_idx),
        .cmd     (cmd),
        .rsp     (dp_rsp),
        .mem_req (mem_req)
    );

endmodule

/* verification/tb_dcache_mem.sv */
`timescale 1ns/1ps

module tb_dcache_mem #(
    parameter logic [31:0] FILL_KEY = 32'h5a3c_96e1
) (
    input  logic                      CLK,
    input  logic                      nRST,
    input  logic                      rand_lat,   // random dwait when set
    input  dcache_bus_pkg::mem_req_t  mem_req,
    output dcache_bus_pkg::mem_rsp_t  mem_rsp
);

    dcache_addr_pkg::word_t mem [0:1023];   // 4 KB of words
    logic [32:0]            log_q [$];      // {wen, addr} per finished transfer
    logic [31:0]            rng_state;
    logic [1:0]             wait_cnt;       // latency of the transfer in progress
    logic                   active;
    logic [9:0]             widx;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = (32'(i) << 2) ^ FILL_KEY;   // byte address of the word
        end
    end

    assign active        = mem_req.ren || mem_req.wen;
    assign widx          = mem_req.addr[11:2];
    assign mem_rsp.dwait = active && (wait_cnt != 2'd0);
    assign mem_rsp.load  = mem[widx];

    // next latency is drawn when a transfer completes
    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_cnt  <= 2'd0;
            rng_state <= 32'd92;
        end else if (active) begin
            if (wait_cnt != 2'd0) begin
                wait_cnt <= wait_cnt - 2'd1;
            end else begin
                if (mem_req.wen) begin
                    mem[widx] <= mem_req.store;
                end
                log_q.push_back({mem_req.wen, mem_req.addr});
                rng_state <= xorshift(rng_state);
                wait_cnt  <= rand_lat ? rng_state[1:0] : 2'd0;
            end
        end
    end

endmodule

/* verification/tb_dcache.sv */
`timescale 1ns/1ps
`include "dcache_defs.svh"

module tb_dcache;

    localparam int          TIMEOUT  = 400;
    localparam logic [31:0] FILL_KEY = 32'h5a3c_96e1;

    logic                      CLK;
    logic                      nRST;
    logic                      halt;
    logic                      rand_lat;
    dcache_bus_pkg::dp_req_t   dp_req;
    dcache_bus_pkg::dp_rsp_t   dp_rsp;
    dcache_bus_pkg::mem_req_t  mem_req;
    dcache_bus_pkg::mem_rsp_t  mem_rsp;

    // expected memory and cache contents
    dcache_addr_pkg::word_t    ref_mem [0:1023];
    dcache_addr_pkg::frame_t   mdl [0:`DC_SETS-1][0:1];
    logic                      mdl_lru [0:`DC_SETS-1];
    logic [32:0]               exp_log [$];   // {wen, addr}

    int value_errs;
    int timeout_errs;

    dcache i_dut (
        .CLK     (CLK),
        .nRST    (nRST),
        .dp_req  (dp_req),
        .halt    (halt),
        .dp_rsp  (dp_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    tb_dcache_mem #(.FILL_KEY(FILL_KEY)) i_mem (
        .CLK      (CLK),
        .nRST     (nRST),
        .rand_lat (rand_lat),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp)
    );

    initial CLK = 1'b0;
    always #2 CLK = ~CLK;

    task automatic apply_reset();
        nRST   = 1'b0;
        halt   = 1'b0;
        dp_req = '0;
        repeat (16) @(negedge CLK);
        nRST = 1'b1;
        for (int s = 0; s < `DC_SETS; s++) begin
            mdl[s][0]  = '0;   // dirty data is lost on reset
            mdl[s][1]  = '0;
            mdl_lru[s] = 1'b0;
        end
        i_mem.log_q.delete();
        #1;
        if (dp_rsp.hit || dp_rsp.flushed || mem_req.ren || mem_req.wen) begin
            $display("FAILED reset: expected outputs 0000 actual %b",
                     {dp_rsp.hit, dp_rsp.flushed, mem_req.ren, mem_req.wen});
            value_errs++;
        end
    endtask

    // both words of a dirty frame go out, word 0 first
    task automatic write_back_model(input logic [2:0] s, input logic w);
        logic [31:0] a;
        for (int b = 0; b < 2; b++) begin
            a = {mdl[s][w].tag, s, 1'(b), 2'b00};
            exp_log.push_back({1'b1, a});
            ref_mem[a[11:2]] = mdl[s][w].data[b];
        end
        mdl[s][w].dirty = 1'b0;
    endtask

    task automatic predict_access(input logic wr, input logic [31:0] addr,
                                  input logic [31:0] data, output logic [31:0] value,
                                  output logic hit);
        logic [2:0]  s;
        logic [25:0] tag;
        logic        w;
        logic [31:0] a;
        s   = addr[5:3];
        tag = addr[31:6];
        hit = 1'b0;
        w   = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (mdl[s][i].valid && mdl[s][i].tag == tag) begin
                hit = 1'b1;
                w   = 1'(i);
            end
        end
        if (!hit) begin
            w = ~mdl_lru[s];   // way not last used
            if (mdl[s][w].dirty) begin
                write_back_model(s, w);
            end
            for (int b = 0; b < 2; b++) begin
                a = {tag, s, 1'(b), 2'b00};
                exp_log.push_back({1'b0, a});
                mdl[s][w].data[b] = ref_mem[a[11:2]];
            end
            mdl[s][w].tag   = tag;
            mdl[s][w].valid = 1'b1;
            mdl[s][w].dirty = 1'b0;
        end
        if (wr) begin
            mdl[s][w].data[addr[2]] = data;
            mdl[s][w].dirty         = 1'b1;
        end
        value      = mdl[s][w].data[addr[2]];
        mdl_lru[s] = w;
    endtask

    task automatic check_traffic(input string name);
        if (i_mem.log_q.size() != exp_log.size()) begin
            $display("FAILED %s: memory transfers expected %0d actual %0d",
                     name, exp_log.size(), i_mem.log_q.size());
            value_errs++;
        end else begin
            foreach (exp_log[i]) begin
                if (i_mem.log_q[i] != exp_log[i]) begin
                    $display("FAILED %s: transfer %0d expected %h actual %h",
                             name, i, exp_log[i], i_mem.log_q[i]);
                    value_errs++;
                end
            end
        end
        exp_log.delete();
        i_mem.log_q.delete();
    endtask

    // one request held until dhit, then checked against the model
    task automatic access(input string name, input logic wr, input logic [31:0] addr,
                          input logic [31:0] data);
        logic [31:0] exp_val;
        logic        exp_hit;
        int          cycles;
        predict_access(wr, addr, data, exp_val, exp_hit);
        @(negedge CLK);
        dp_req.ren       = !wr;
        dp_req.wen       = wr;
        dp_req.addr.word = addr;
        dp_req.store     = data;
        cycles = 0;
        #1;
        while (!dp_rsp.hit && cycles < TIMEOUT) begin
            @(negedge CLK);
            #1;
            cycles++;
        end
        if (!dp_rsp.hit) begin
            $display("timeout: %s never saw dhit for address %h", name, addr);
            timeout_errs++;
        end else begin
            if (!wr && dp_rsp.load != exp_val) begin
                $display("FAILED %s: load at %h expected %h actual %h",
                         name, addr, exp_val, dp_rsp.load);
                value_errs++;
            end
            if (exp_hit && cycles != 0) begin
                $display("FAILED %s: hit latency at %h expected 0 actual %0d",
                         name, addr, cycles);
                value_errs++;
            end
        end
        @(negedge CLK);
        dp_req = '0;
        check_traffic(name);
    endtask

    task automatic halt_flush(input string name);
        int cycles;
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < `DC_SETS; s++) begin
                if (mdl[s][w].dirty) begin
                    write_back_model(3'(s), 1'(w));
                end
            end
        end
        @(negedge CLK);
        halt   = 1'b1;
        cycles = 0;
        #1;
        while (!dp_rsp.flushed && cycles < TIMEOUT) begin
            @(negedge CLK);
            #1;
            cycles++;
        end
        if (!dp_rsp.flushed) begin
            $display("timeout: %s, flushed did not rise after halt", name);
            timeout_errs++;
        end
        check_traffic(name);
        for (int i = 0; i < 1024; i++) begin
            if (i_mem.mem[i] != ref_mem[i]) begin
                $display("FAILED %s: word at %h expected %h actual %h",
                         name, 32'(i) << 2, ref_mem[i], i_mem.mem[i]);
                value_errs++;
            end
        end
    endtask

    task automatic read_miss_test();
        access("read_miss", 1'b0, 32'h0000_004c, '0);   // empty set 1
        access("read_miss", 1'b0, 32'h0000_004c, '0);
    endtask

    task automatic write_hit_test();
        access("write_hit", 1'b1, 32'h0000_0048, 32'hcafe_0001);
        access("write_hit", 1'b0, 32'h0000_0048, '0);
        access("write_hit", 1'b0, 32'h0000_004c, '0);
    endtask

    // A, B and C all map to set 2
    task automatic replace_test();
        access("replace", 1'b1, 32'h0000_0090, 32'h1111_aaaa);
        access("replace", 1'b1, 32'h0000_00d4, 32'h2222_bbbb);
        access("replace", 1'b0, 32'h0000_0090, '0);
        access("replace", 1'b0, 32'h0000_00d4, '0);
        access("replace", 1'b1, 32'h0000_0094, 32'h3333_cccc);   // A used last
        access("replace", 1'b0, 32'h0000_0110, '0);              // dirty B goes out
        access("replace", 1'b0, 32'h0000_00d4, '0);
    endtask

    task automatic flush_test();
        access("flush", 1'b1, 32'h0000_0058, 32'h4444_0001);   // set 3
        access("flush", 1'b1, 32'h0000_009c, 32'h4444_0002);   // set 3, other way
        access("flush", 1'b1, 32'h0000_00e8, 32'h4444_0003);   // set 5
        access("flush", 1'b0, 32'h0000_01a0, '0);              // stays clean
        halt_flush("flush");
    endtask

    initial begin
        value_errs   = 0;
        timeout_errs = 0;
        rand_lat     = 1'b0;
        halt         = 1'b0;
        nRST         = 1'b0;
        dp_req       = '0;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = (32'(i) << 2) ^ FILL_KEY;
        end

        apply_reset();
        read_miss_test();
        write_hit_test();
        replace_test();
        flush_test();

        // same sequence again with dwait stretched
        rand_lat = 1'b1;
        apply_reset();
        read_miss_test();
        write_hit_test();
        replace_test();

        $display("errors: %0d wrong values, %0d timeouts", value_errs, timeout_errs);
        if (value_errs == 0 && timeout_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+design
design/dcache_addr_pkg.sv
design/dcache_bus_pkg.sv
design/dcache_lookup.sv
design/dcache_frames.sv
design/dcache_mem_ctrl.sv
design/dcache.sv
verification/tb_dcache_mem.sv
verification/tb_dcache.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the dcache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_dcache -o tb_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_dcache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
    exit 0
fi
exit 1
